// File: vlog.f
src/r8051_pkg.sv
src/alu.sv
src/inst_decoder.sv
src/fetch_unit.sv
src/data_access.sv
src/acc_psw_regs.sv
src/r8051_lite_top.sv
testbench/tb_checker.sv
testbench/tb_r8051.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_r8051 -o sim_r8051
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_r8051 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" sim.log; then
    exit 0
fi
exit 1

// File: testbench/tb_r8051.sv
`timescale 1ns/1ps

module tb_r8051
    import r8051_pkg::*;
;

    localparam int n_tests   = 7;
    localparam int max_bytes = 16;

    logic         clk;
    logic         rst;
    logic         cpu_en;
    logic         cpu_restart;
    logic         rom_en;
    code_addr_t   rom_addr;
    byte_t        rom_byte = 8'h00;
    byte_t        rom_q;
    ram_rd_t      ram_rd;
    byte_t        ram_rd_byte;
    logic         ram_rd_vld;
    ram_wr_t      ram_wr;
    logic         arm;
    logic [127:0] cur_name;
    ram_wr_t      exp_a;
    ram_wr_t      exp_b;
    int           wr_seen;
    int           err_count;
    int           tests_run;
    int           tests_failed;

    byte_t rom [256];
    byte_t ram [256];
    int    seed = 32'hc9d3;
    int    cycles = 0;
    int    cycle_limit = 50;

    // test table
    logic [127:0]           t_name [n_tests];
    int                     t_len  [n_tests];
    logic [8*max_bytes-1:0] t_code [n_tests];
    ram_wr_t                t_exp_a [n_tests];
    ram_wr_t                t_exp_b [n_tests];

    r8051_lite_top #(
        .reset_pc(16'h0000)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .cpu_en     (cpu_en),
        .cpu_restart(cpu_restart),
        .rom_en     (rom_en),
        .rom_addr   (rom_addr),
        .rom_byte   (rom_byte),
        .ram_rd     (ram_rd),
        .ram_rd_byte(ram_rd_byte),
        .ram_rd_vld (ram_rd_vld),
        .ram_wr     (ram_wr)
    );

    tb_checker u_chk (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .arm         (arm),
        .test_name   (cur_name),
        .exp_a       (exp_a),
        .exp_b       (exp_b),
        .ram_rd      (ram_rd),
        .ram_wr      (ram_wr),
        .wr_seen     (wr_seen),
        .err_count   (err_count),
        .tests_run   (tests_run),
        .tests_failed(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // code rom, one cycle latency, holds its output while disabled
    always @(posedge clk) begin
        if (rom_en) begin
            rom_q = rom[rom_addr[7:0]];
            #1 rom_byte = rom_q;
        end
    end

    always @(negedge clk) begin
        if (ram_wr.en) begin
            ram[ram_wr.addr] = ram_wr.data;
        end
    end

    // read answer after 1 to 3 cycles
    initial begin
        int         lat;
        data_addr_t addr;
        ram_rd_vld  = 1'b0;
        ram_rd_byte = 8'h00;
        forever begin
            @(negedge clk);
            if (ram_rd.en) begin
                addr = ram_rd.addr;
                lat  = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                repeat (lat) @(posedge clk);
                #1;
                ram_rd_vld  = 1'b1;
                ram_rd_byte = ram[addr];
                @(posedge clk);
                #1;
                ram_rd_vld = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic set_test(input int idx, input logic [127:0] name, input int len,
                            input logic [8*max_bytes-1:0] code,
                            input ram_wr_t ea, input ram_wr_t eb);
        t_name[idx]  = name;
        t_len[idx]   = len;
        t_code[idx]  = code;
        t_exp_a[idx] = ea;
        t_exp_b[idx] = eb;
    endtask

    task automatic load_memories(input int idx);
        for (int i = 0; i < 256; i++) begin
            rom[i] = 8'h00;
            ram[i] = 8'(i) ^ 8'ha5;
        end
        for (int k = 0; k < t_len[idx]; k++) begin
            rom[k] = t_code[idx][8*(t_len[idx]-1-k) +: 8];
        end
    endtask

    initial begin
        int total;
        rst         = 1'b1;
        cpu_en      = 1'b0;
        cpu_restart = 1'b0;
        arm         = 1'b0;
        cur_name    = '0;
        exp_a       = '0;
        exp_b       = '0;

        set_test(0, "moves", 7, 56'h74_5a_f5_30_75_31_c3,
                 {1'b1, 8'h30, 8'h5a}, {1'b1, 8'h31, 8'hc3});
        // psw after subb is C=1 AC=0 OV=0 P=0
        set_test(1, "arith_flags", 14, 112'h74_9c_24_7a_34_05_94_20_f5_40_e5_d0_f5_41,
                 {1'b1, 8'h40, 8'hfc}, {1'b1, 8'h41, 8'h80});
        set_test(2, "direct_ops", 12, 96'he5_10_55_11_45_12_65_13_25_10_f5_50,
                 {1'b1, 8'h50, 8'hb6}, '0);
        set_test(3, "store_load", 9, 72'h74_11_75_20_3c_25_20_f5_21,
                 {1'b1, 8'h20, 8'h3c}, {1'b1, 8'h21, 8'h4d});
        // a5 is not decoded, acts as nop
        set_test(4, "unary", 12, 96'h74_ff_04_14_14_f4_a5_f5_60_e4_f5_61,
                 {1'b1, 8'h60, 8'h01}, {1'b1, 8'h61, 8'h00});
        // every writable psw bit set directly, parity from the cleared acc
        set_test(5, "psw_write", 8, 64'he4_75_d0_fe_e5_d0_f5_42,
                 {1'b1, 8'h42, 8'hfe}, '0);
        set_test(6, "restart", 4, 32'h74_77_f5_70,
                 {1'b1, 8'h70, 8'h77}, '0);

        total = 0;
        for (int i = 0; i < n_tests; i++) begin
            total += t_len[i];
        end
        cycle_limit = total * 4 + 50;

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        for (int t = 0; t < n_tests; t++) begin
            @(posedge clk);
            #1;
            load_memories(t);
            cur_name    = t_name[t];
            exp_a       = t_exp_a[t];
            exp_b       = t_exp_b[t];
            cpu_restart = 1'b1;
            @(posedge clk);
            #1;
            cpu_restart = 1'b0;
            arm         = 1'b1;
            // core held off, nothing may reach the ram ports
            repeat (4) @(posedge clk);
            #1 cpu_en = 1'b1;
            while (wr_seen < int'(exp_a.en) + int'(exp_b.en)) begin
                @(posedge clk);
            end
            #1 cpu_en = 1'b0;
            @(posedge clk);
            #1 arm = 1'b0;
        end

        repeat (2) @(posedge clk);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_run == n_tests) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import r8051_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cpu_en,
    input  logic         arm,
    input  logic [127:0] test_name,
    input  ram_wr_t      exp_a,
    input  ram_wr_t      exp_b,
    input  ram_rd_t      ram_rd,
    input  ram_wr_t      ram_wr,
    output int           wr_seen,
    output int           err_count,
    output int           tests_run,
    output int           tests_failed
);

    int      test_errs;
    int      exp_n;
    logic    arm_q;
    ram_wr_t exp_cur;

    initial begin
        wr_seen      = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        arm_q        = 1'b0;
    end

    assign exp_n = int'(exp_a.en) + int'(exp_b.en);

    // sampled mid-cycle where all DUT outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (arm && !arm_q) begin
                wr_seen   = 0;
                test_errs = 0;
            end
            if (!cpu_en && (ram_rd.en || ram_wr.en)) begin
                $display("%0s: RAM enable active while cpu_en is low", test_name);
                test_errs++;
                err_count++;
            end
            if (ram_wr.en) begin
                if (!arm || wr_seen >= exp_n) begin
                    $display("%0s: unexpected RAM write %h=%h", test_name,
                             ram_wr.addr, ram_wr.data);
                    test_errs++;
                    err_count++;
                end else begin
                    exp_cur = (wr_seen == 0) ? exp_a : exp_b;
                    if (ram_wr.addr != exp_cur.addr || ram_wr.data != exp_cur.data) begin
                        $display("ERROR %0s write %0d: expected %h=%h, actual %h=%h",
                                 test_name, wr_seen, exp_cur.addr, exp_cur.data,
                                 ram_wr.addr, ram_wr.data);
                        test_errs++;
                        err_count++;
                    end
                    wr_seen++;
                end
            end
            if (!arm && arm_q) begin
                tests_run++;
                if (test_errs == 0) begin
                    $display("%0s: pass, %0d writes", test_name, wr_seen);
                end else begin
                    tests_failed++;
                    $display("%0s: FAIL, %0d errors", test_name, test_errs);
                end
            end
            arm_q = arm;
        end
    end

endmodule

// File: src/r8051_lite_top.sv
`timescale 1ns/1ps

module r8051_lite_top
    import r8051_pkg::*;
#(
    parameter code_addr_t reset_pc = 16'h0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_en,
    input  logic       cpu_restart,
    output logic       rom_en,
    output code_addr_t rom_addr,
    input  byte_t      rom_byte,
    output ram_rd_t    ram_rd,
    input  byte_t      ram_rd_byte,
    input  logic       ram_rd_vld,
    output ram_wr_t    ram_wr
);

    logic      work_en;
    logic      len2;
    logic      len3;
    opcode_e   opa;
    opcode_e   opb;
    opcode_e   opc;
    byte_t     cmd0;
    byte_t     cmd1;
    dec_ctrl_t ctrl_b;
    dec_ctrl_t ctrl_c;
    dec_ctrl_t ctrl;
    byte_t     data0;
    byte_t     acc;
    byte_t     psw;
    byte_t     alu_b;
    byte_t     alu_y;
    logic      alu_c;
    logic      alu_ac;
    logic      alu_ov;
    logic      wr_internal;
    ram_wr_t   wr_req;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .cpu_restart(cpu_restart),
        .work_en    (work_en),
        .len2       (len2),
        .len3       (len3),
        .rom_byte   (rom_byte),
        .rom_en     (rom_en),
        .rom_addr   (rom_addr),
        .opa        (opa),
        .opb        (opb),
        .opc        (opc),
        .cmd0       (cmd0),
        .cmd1       (cmd1)
    );

    inst_decoder u_dec (
        .opa   (opa),
        .opb   (opb),
        .opc   (opc),
        .len2  (len2),
        .len3  (len3),
        .ctrl_b(ctrl_b),
        .ctrl_c(ctrl_c)
    );

    // b and c never both act in one cycle
    assign ctrl = (ctrl_c.acc_we | ctrl_c.wr_dir_imm) ? ctrl_c : ctrl_b;

    assign wr_req.en   = work_en & (ctrl.wr_dir_a | ctrl.wr_dir_imm);
    assign wr_req.addr = ctrl.wr_dir_imm ? cmd1 : cmd0;
    assign wr_req.data = ctrl.wr_dir_a ? acc : cmd0;

    assign wr_internal = (wr_req.addr == sfr_acc) | (wr_req.addr == sfr_psw);

    always_comb begin
        ram_wr    = wr_req;
        ram_wr.en = wr_req.en & ~wr_internal;
    end

    data_access u_data (
        .clk        (clk),
        .rst        (rst),
        .cpu_restart(cpu_restart),
        .cpu_en     (cpu_en),
        .rd_req     (ctrl_b.rd_dir),
        .rd_addr    (cmd0),
        .wr         (ram_wr),
        .acc        (acc),
        .psw        (psw),
        .ram_rd_byte(ram_rd_byte),
        .ram_rd_vld (ram_rd_vld),
        .ram_rd     (ram_rd),
        .work_en    (work_en),
        .data0      (data0)
    );

    assign alu_b = ctrl.operand_imm ? cmd0 : data0;

    alu u_alu (
        .op (ctrl.alu_op),
        .a  (acc),
        .b  (alu_b),
        .cin(ctrl.use_carry & psw[psw_c]),
        .y  (alu_y),
        .c  (alu_c),
        .ac (alu_ac),
        .ov (alu_ov)
    );

    acc_psw_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .work_en(work_en),
        .ctrl   (ctrl),
        .alu_y  (alu_y),
        .alu_c  (alu_c),
        .alu_ac (alu_ac),
        .alu_ov (alu_ov),
        .wr     (wr_req),
        .acc    (acc),
        .psw    (psw)
    );

endmodule

// File: src/acc_psw_regs.sv
`timescale 1ns/1ps

module acc_psw_regs
    import r8051_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      work_en,
    input  dec_ctrl_t ctrl,
    input  byte_t     alu_y,
    input  logic      alu_c,
    input  logic      alu_ac,
    input  logic      alu_ov,
    input  ram_wr_t   wr,
    output byte_t     acc,
    output byte_t     psw
);

    logic       acc_wr;
    logic       psw_wr;
    logic       c_flag;
    logic       ac_flag;
    logic       ov_flag;
    // psw bits 5, 4, 3 and 1
    logic [3:0] user_bits;

    assign acc_wr = wr.en & (wr.addr == sfr_acc);
    assign psw_wr = wr.en & (wr.addr == sfr_psw);

    // direct write wins over the alu
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= 8'h00;
        end else if (work_en) begin
            if (acc_wr) begin
                acc <= wr.data;
            end else if (ctrl.acc_we) begin
                acc <= alu_y;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            c_flag    <= 1'b0;
            ac_flag   <= 1'b0;
            ov_flag   <= 1'b0;
            user_bits <= 4'h0;
        end else if (work_en) begin
            if (psw_wr) begin
                c_flag    <= wr.data[psw_c];
                ac_flag   <= wr.data[psw_ac];
                ov_flag   <= wr.data[psw_ov];
                user_bits <= {wr.data[5:3], wr.data[1]};
            end else if (ctrl.flags_we) begin
                c_flag  <= alu_c;
                ac_flag <= alu_ac;
                ov_flag <= alu_ov;
            end
        end
    end

    always_comb begin
        psw         = {2'b00, user_bits[3:1], 1'b0, user_bits[0], 1'b0};
        psw[psw_c]  = c_flag;
        psw[psw_ac] = ac_flag;
        psw[psw_ov] = ov_flag;
        // parity tracks acc at all times
        psw[psw_p]  = ^acc;
    end

endmodule

// File: src/data_access.sv
`timescale 1ns/1ps

module data_access
    import r8051_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_restart,
    input  logic       cpu_en,
    input  logic       rd_req,
    input  data_addr_t rd_addr,
    input  ram_wr_t    wr,
    input  byte_t      acc,
    input  byte_t      psw,
    input  byte_t      ram_rd_byte,
    input  logic       ram_rd_vld,
    output ram_rd_t    ram_rd,
    output logic       work_en,
    output byte_t      data0
);

    typedef enum logic {
        rd_idle,
        rd_waiting
    } rd_state_e;

    rd_state_e  rd_state;
    logic       read_internal;
    logic       same_hit;
    logic       fwd_flag;
    byte_t      fwd_byte;
    // one-hot, bit 1 acc and bit 0 psw
    logic [1:0] sfr_sel;

    assign work_en = cpu_en & ~cpu_restart & ~((rd_state == rd_waiting) & ~ram_rd_vld);

    assign read_internal = (rd_addr == sfr_acc) | (rd_addr == sfr_psw);
    assign same_hit      = rd_req & wr.en & (wr.addr == rd_addr);

    assign ram_rd.en   = work_en & rd_req & ~read_internal & ~same_hit;
    assign ram_rd.addr = rd_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= rd_idle;
        end else if (cpu_restart) begin
            rd_state <= rd_idle;
        end else if (work_en) begin
            rd_state <= ram_rd.en ? rd_waiting : rd_idle;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_flag <= 1'b0;
            sfr_sel  <= 2'b00;
        end else if (cpu_restart) begin
            fwd_flag <= 1'b0;
            sfr_sel  <= 2'b00;
        end else if (work_en) begin
            fwd_flag <= same_hit;
            sfr_sel  <= {rd_req & (rd_addr == sfr_acc), rd_req & (rd_addr == sfr_psw)};
        end
    end

    always_ff @(posedge clk) begin
        if (work_en && same_hit) begin
            fwd_byte <= wr.data;
        end
    end

    // acc/psw are sampled here, after any write to them has landed
    always_comb begin
        if (fwd_flag) begin
            data0 = fwd_byte;
        end else if (sfr_sel[1]) begin
            data0 = acc;
        end else if (sfr_sel[0]) begin
            data0 = psw;
        end else begin
            data0 = ram_rd_byte;
        end
    end

    a_vld_only_when_waiting: assert property (@(posedge clk) disable iff (rst)
        ram_rd_vld |-> rd_state == rd_waiting)
        else $error("ram_rd_vld without an outstanding read");

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import r8051_pkg::*;
#(
    parameter code_addr_t reset_pc = 16'h0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_restart,
    input  logic       work_en,
    input  logic       len2,
    input  logic       len3,
    input  byte_t      rom_byte,
    output logic       rom_en,
    output code_addr_t rom_addr,
    output opcode_e    opa,
    output opcode_e    opb,
    output opcode_e    opc,
    output byte_t      cmd0,
    output byte_t      cmd1
);

    code_addr_t pc;
    byte_t      cmd1_q;
    byte_t      cmd2;
    // bit 1 marks cmd0 as an opcode, bit 2 marks cmd1 as one
    logic [2:0] cmd_flag;

    assign rom_en   = work_en;
    assign rom_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (cpu_restart) begin
            pc <= reset_pc;
        end else if (work_en) begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_flag <= 3'b001;
        end else if (cpu_restart) begin
            cmd_flag <= 3'b001;
        end else if (work_en) begin
            if (len2) begin
                cmd_flag <= 3'b101;
            end else if (len3) begin
                cmd_flag <= 3'b100;
            end else begin
                cmd_flag <= {cmd_flag[1:0], 1'b1};
            end
        end
    end

    // operand byte, one stage behind cmd0
    always_ff @(posedge clk) begin
        if (work_en) begin
            cmd1_q <= cmd0;
        end
    end

    // third-stage opcode, cleared so a restart leaves no stale action behind
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd2 <= 8'h00;
        end else if (cpu_restart) begin
            cmd2 <= 8'h00;
        end else if (work_en) begin
            cmd2 <= opb;
        end
    end

    assign cmd0 = rom_byte;
    assign cmd1 = cmd1_q;

    assign opa = opcode_e'(cmd_flag[1] ? cmd0 : 8'h00);
    assign opb = opcode_e'(cmd_flag[2] ? cmd1_q : 8'h00);
    assign opc = opcode_e'(cmd2);

    a_len_from_opcode: assert property (@(posedge clk) disable iff (rst)
        (len2 || len3) |-> cmd_flag[1])
        else $error("length class decoded from an operand byte");

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import r8051_pkg::*;
(
    input  opcode_e   opa,
    input  opcode_e   opb,
    input  opcode_e   opc,
    output logic      len2,
    output logic      len3,
    output dec_ctrl_t ctrl_b,
    output dec_ctrl_t ctrl_c
);

    dec_ctrl_t ctrl_a;

    function automatic dec_ctrl_t decode(opcode_e op, logic at_c);
        dec_ctrl_t d;
        logic      imm_form;
        logic      dir_form;
        logic      unary;
        logic      arith;
        d        = '0;
        imm_form = 1'b0;
        dir_form = 1'b0;
        unary    = 1'b0;
        arith    = 1'b0;

        case (op)
            op_add_imm, op_add_dir: begin
                d.alu_op = alu_add;
                arith    = 1'b1;
            end
            op_addc_imm, op_addc_dir: begin
                d.alu_op    = alu_add;
                d.use_carry = 1'b1;
                arith       = 1'b1;
            end
            op_subb_imm, op_subb_dir: begin
                d.alu_op    = alu_sub;
                d.use_carry = 1'b1;
                arith       = 1'b1;
            end
            op_anl_imm, op_anl_dir: d.alu_op = alu_and;
            op_orl_imm, op_orl_dir: d.alu_op = alu_or;
            op_xrl_imm, op_xrl_dir: d.alu_op = alu_xor;
            op_inc_a:               d.alu_op = alu_inc;
            op_dec_a:               d.alu_op = alu_dec;
            op_clr_a:               d.alu_op = alu_clr;
            op_cpl_a:               d.alu_op = alu_cpl;
            default:                d.alu_op = alu_pass;
        endcase

        case (op)
            op_add_imm, op_addc_imm, op_subb_imm, op_anl_imm, op_orl_imm,
            op_xrl_imm, op_mov_a_imm:
                imm_form = 1'b1;
            op_add_dir, op_addc_dir, op_subb_dir, op_anl_dir, op_orl_dir,
            op_xrl_dir, op_mov_a_dir:
                dir_form = 1'b1;
            op_inc_a, op_dec_a, op_clr_a, op_cpl_a:
                unary = 1'b1;
            default: ;
        endcase

        d.len2 = imm_form | dir_form | (op == op_mov_dir_a);
        d.len3 = (op == op_mov_dir_imm);

        // direct operands are read at b and consumed at c
        if (at_c) begin
            d.acc_we     = dir_form;
            d.wr_dir_imm = d.len3;
        end else begin
            d.acc_we      = imm_form | unary;
            d.operand_imm = imm_form;
            d.rd_dir      = dir_form;
            d.wr_dir_a    = (op == op_mov_dir_a);
        end
        d.flags_we  = arith & d.acc_we;
        d.use_carry = d.use_carry & d.acc_we;
        return d;
    endfunction

    assign ctrl_a = decode(opa, 1'b0);
    assign len2   = ctrl_a.len2;
    assign len3   = ctrl_a.len3;

    assign ctrl_b = decode(opb, 1'b0);
    assign ctrl_c = decode(opc, 1'b1);

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu
    import r8051_pkg::*;
(
    input  alu_op_e op,
    input  byte_t   a,
    input  byte_t   b,
    input  logic    cin,
    output byte_t   y,
    output logic    c,
    output logic    ac,
    output logic    ov
);

    logic       sub;
    byte_t      add_b;
    logic       add_c;
    logic [4:0] low;
    logic [3:0] high;
    logic [1:0] top;
    byte_t      sum;

    always_comb begin
        sub   = (op == alu_sub) || (op == alu_dec);
        add_b = b;
        add_c = cin;
        if (op == alu_inc || op == alu_dec) begin
            add_b = 8'h00;
            add_c = 1'b1;
        end
    end

    // nibble, bits 6:4 and bit 7 so AC and OV fall out of one sum
    assign low  = sub ? {1'b0, a[3:0]} - {1'b0, add_b[3:0]} - {4'b0, add_c}
                      : {1'b0, a[3:0]} + {1'b0, add_b[3:0]} + {4'b0, add_c};
    assign high = sub ? {1'b0, a[6:4]} - {1'b0, add_b[6:4]} - {3'b0, low[4]}
                      : {1'b0, a[6:4]} + {1'b0, add_b[6:4]} + {3'b0, low[4]};
    assign top  = sub ? {1'b0, a[7]} - {1'b0, add_b[7]} - {1'b0, high[3]}
                      : {1'b0, a[7]} + {1'b0, add_b[7]} + {1'b0, high[3]};

    assign sum = {top[0], high[2:0], low[3:0]};
    assign c   = top[1];
    assign ac  = low[4];
    assign ov  = top[1] ^ high[3];

    always_comb begin
        case (op)
            alu_add, alu_sub, alu_inc, alu_dec: y = sum;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_xor: y = a ^ b;
            alu_clr: y = 8'h00;
            alu_cpl: y = ~a;
            default: y = b;
        endcase
    end

endmodule

// File: src/r8051_pkg.sv
package r8051_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] code_addr_t;
    typedef logic [7:0]  data_addr_t;

    // kept subset, real 8051 encodings
    typedef enum logic [7:0] {
        op_nop         = 8'h00,
        op_inc_a       = 8'h04,
        op_dec_a       = 8'h14,
        op_add_imm     = 8'h24,
        op_add_dir     = 8'h25,
        op_addc_imm    = 8'h34,
        op_addc_dir    = 8'h35,
        op_orl_imm     = 8'h44,
        op_orl_dir     = 8'h45,
        op_anl_imm     = 8'h54,
        op_anl_dir     = 8'h55,
        op_xrl_imm     = 8'h64,
        op_xrl_dir     = 8'h65,
        op_mov_a_imm   = 8'h74,
        op_mov_dir_imm = 8'h75,
        op_subb_imm    = 8'h94,
        op_subb_dir    = 8'h95,
        op_clr_a       = 8'he4,
        op_mov_a_dir   = 8'he5,
        op_cpl_a       = 8'hf4,
        op_mov_dir_a   = 8'hf5
    } opcode_e;

    typedef enum logic [3:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_inc,
        alu_dec,
        alu_clr,
        alu_cpl
    } alu_op_e;

    // sfrs held inside the core
    localparam data_addr_t sfr_acc = 8'he0;
    localparam data_addr_t sfr_psw = 8'hd0;

    localparam int psw_c  = 7;
    localparam int psw_ac = 6;
    localparam int psw_ov = 2;
    localparam int psw_p  = 0;

    typedef struct packed {
        logic       en;
        data_addr_t addr;
    } ram_rd_t;

    typedef struct packed {
        logic       en;
        data_addr_t addr;
        byte_t      data;
    } ram_wr_t;

    typedef struct packed {
        logic    len2;
        logic    len3;
        logic    rd_dir;
        logic    operand_imm;
        logic    acc_we;
        alu_op_e alu_op;
        logic    flags_we;
        logic    use_carry;
        logic    wr_dir_a;
        logic    wr_dir_imm;
    } dec_ctrl_t;

endpackage
